// File: design/ram_geom_pkg.sv
// Geometry of the 16-kbit array: 512 words of 32 bits, no parity bits
// A narrow lane at bit address a*width always sits inside one word
// Widths below are fixed; port widths are derived from them per instance

package ram_geom_pkg;

   localparam int word_bits      = 32;                     // Storage word width
   localparam int word_count     = 512;                    // Words in the array
   localparam int byte_bits      = 8;                      // Byte write enable granule
   localparam int byte_count     = word_bits / byte_bits;  // Byte enables per word
   localparam int word_addr_bits = $clog2(word_count);     // Word index width
   localparam int lane_off_bits  = $clog2(word_bits);      // Bit offset inside a word

   // Full bit address, word index on top and lane offset below
   localparam int bit_addr_bits  = word_addr_bits + lane_off_bits;  // 14

   // Widths that carry a meaning across the modules
   typedef logic [word_bits-1:0]      word_t;       // One storage word
   typedef logic [word_addr_bits-1:0] word_addr_t;  // Word index
   typedef logic [lane_off_bits-1:0]  lane_off_t;   // Lane bit offset in a word
   typedef logic [byte_count-1:0]     byte_en_t;    // Write byte enables
   typedef logic [word_bits-1:0]      bit_mask_t;   // Per-bit write mask

endpackage

// File: design/ram_port_pkg.sv
// Word-level request records that go from the address decode into the array
// The write data is already replicated over the word, the mask picks the lane

package ram_port_pkg;

   import ram_geom_pkg::*;

   // Write side, sampled on wclk
   typedef struct packed {
      logic       wr_en;  // Write strobe for this cycle
      word_addr_t addr;   // Target word
      bit_mask_t  mask;   // Bits to update, lane and byte enables merged
      word_t      data;   // Write data copied into every lane
   } wr_req_t;

   // Read side, sampled on rclk
   typedef struct packed {
      logic       rd_en;  // Latch enable for the read word
      word_addr_t addr;   // Source word
      lane_off_t  off;    // Lane position, used after the latch
   } rd_req_t;

endpackage

// File: design/access_decode.sv
// Combinational decode of narrow port addresses into word requests
// Write widths below 8 bits take only web_i[0] as the lane enable
// Both widths must be 0..5 (1 to 32 bits)
`timescale 1ns/10ps

module access_decode #(
   parameter int log2_width_wr = 5,  // Write width is 1 << log2_width_wr
   parameter int log2_width_rd = 5   // Read width is 1 << log2_width_rd
) (
   input  logic [ram_geom_pkg::bit_addr_bits-log2_width_wr-1:0] waddr_i,  // Narrow write address
   input  logic                                                 we_i,     // Write strobe
   input  ram_geom_pkg::byte_en_t                               web_i,    // Byte enables
   input  logic [(1 << log2_width_wr)-1:0]                      data_i,   // Narrow write data
   input  logic [ram_geom_pkg::bit_addr_bits-log2_width_rd-1:0] raddr_i,  // Narrow read address
   input  logic                                                 ren_i,    // Read strobe
   output ram_port_pkg::wr_req_t                                wr_req_o, // Word write request
   output ram_port_pkg::rd_req_t                                rd_req_o  // Word read request
);
   import ram_geom_pkg::*;
   import ram_port_pkg::*;

   localparam int wr_width = 1 << log2_width_wr;  // Write lane width in bits

   logic [bit_addr_bits-1:0] wr_bit_addr;  // Flat bit address of the write lane
   logic [bit_addr_bits-1:0] rd_bit_addr;  // Flat bit address of the read lane
   lane_off_t                wr_off;       // Write lane offset in the word
   byte_en_t                 lane_be;      // Byte enables, lane relative
   bit_mask_t                be_bits;      // Byte enables spread to bits
   bit_mask_t                lane_ones;    // Lane-wide ones at offset zero

   // Narrow address a covers bits a*width and up
   assign wr_bit_addr = bit_addr_bits'(waddr_i) << log2_width_wr;
   assign rd_bit_addr = bit_addr_bits'(raddr_i) << log2_width_rd;
   assign wr_off      = wr_bit_addr[lane_off_bits-1:0];  // Low bits select the lane

   assign lane_ones = bit_mask_t'({wr_width{1'b1}});     // Lane footprint before shift
   // Sub-byte lanes follow web_i[0] alone
   assign lane_be   = (wr_width >= byte_bits) ? web_i : {byte_count{web_i[0]}};

   always_comb begin
      for (int k = 0; k < byte_count; k++) begin
         be_bits[byte_bits*k +: byte_bits] = {byte_bits{lane_be[k]}};  // Byte k to 8 bits
      end
   end

   // Write request, mask built at lane position zero then moved into place
   assign wr_req_o.wr_en = we_i;
   assign wr_req_o.addr  = wr_bit_addr[bit_addr_bits-1:lane_off_bits];
   assign wr_req_o.mask  = (be_bits & lane_ones) << wr_off;  // Lane bytes only
   assign wr_req_o.data  = {(word_bits / wr_width){data_i}}; // Same data in every lane

   // Read request, offset travels with the word through the latch
   assign rd_req_o.rd_en = ren_i;
   assign rd_req_o.addr  = rd_bit_addr[bit_addr_bits-1:lane_off_bits];
   assign rd_req_o.off   = rd_bit_addr[lane_off_bits-1:0];

endmodule

// File: design/ram_word_array.sv
// 512 x 32 storage, masked write on wclk, word read latch on rclk
// Read and write of the same word in one cycle give undefined data
// reset_i is synchronous to rclk and clears only the read latch
`timescale 1ns/10ps

module ram_word_array (
   input  logic                    wclk,       // Write port clock
   input  logic                    rclk,       // Read port clock
   input  logic                    reset_i,    // Read side reset, sync to rclk
   input  ram_port_pkg::wr_req_t   wr_req_i,   // Word write request
   input  ram_port_pkg::rd_req_t   rd_req_i,   // Word read request
   output ram_geom_pkg::word_t     rd_word_o,  // Latched read word
   output ram_geom_pkg::lane_off_t rd_off_o    // Lane offset of the latched read
);
   import ram_geom_pkg::*;
   import ram_port_pkg::*;

   word_t mem [word_count];  // Stored data, contents not reset
   word_t wr_old;            // Current contents of the target word
   word_t wr_new;            // Target word after the masked merge

   assign wr_old = mem[wr_req_i.addr];
   // Masked bits take new data, the rest keep their value
   assign wr_new = (wr_old & ~wr_req_i.mask) | (wr_req_i.data & wr_req_i.mask);

   // Write port
   always_ff @(posedge wclk) begin
      if (wr_req_i.wr_en) begin
         mem[wr_req_i.addr] <= wr_new;  // One word per cycle
      end
   end

   // Read port latch, one rclk after ren_i
   always_ff @(posedge rclk) begin
      if (reset_i) begin
         rd_word_o <= '0;  // Zero data until the first read
         rd_off_o  <= '0;
      end else if (rd_req_i.rd_en) begin
         rd_word_o <= mem[rd_req_i.addr];
         rd_off_o  <= rd_req_i.off;      // Keeps lane paired with its word
      end
   end

endmodule

// File: design/read_lane_select.sv
// Picks the read lane out of the latched word, optional output register
// With registers 1 the register loads only while regen_i is high
// With registers 0 the clock, reset and regen_i inputs have no effect
`timescale 1ns/10ps

module read_lane_select #(
   parameter int log2_width_rd = 5,  // Read width is 1 << log2_width_rd
   parameter int registers     = 0   // 1 adds the regen_i output register
) (
   input  logic                          rclk,       // Read port clock
   input  logic                          reset_i,    // Sync reset of the output register
   input  logic                          regen_i,    // Output register load enable
   input  ram_geom_pkg::word_t           rd_word_i,  // Latched word from the array
   input  ram_geom_pkg::lane_off_t       rd_off_i,   // Lane offset of that word
   output logic [(1 << log2_width_rd)-1:0] data_o    // Read data
);
   import ram_geom_pkg::*;

   localparam int rd_width = 1 << log2_width_rd;  // Read lane width in bits

   word_t               word_shifted;  // Requested lane moved to bit zero
   logic [rd_width-1:0] lane;          // Lane bits only

   assign word_shifted = rd_word_i >> rd_off_i;
   assign lane         = word_shifted[rd_width-1:0];  // Upper lanes dropped

   generate
      if (registers != 0) begin : g_out_reg
         logic [rd_width-1:0] out_q;  // Output register

         // One more rclk of latency, held while regen_i is low
         always_ff @(posedge rclk) begin
            if (reset_i) begin
               out_q <= '0;
            end else if (regen_i) begin
               out_q <= lane;
            end
         end

         assign data_o = out_q;
      end else begin : g_no_reg
         assign data_o = lane;  // Straight from the read latch
      end
   endgenerate

endmodule

// File: design/ram_var_width.sv
// Simple dual-port 16-kbit RAM, write and read widths 1..32 bits each
// Write port on wclk, read port on rclk, the clocks are independent
// Read data after one rclk, plus one regen_i cycle with registers 1
// Same-word read and write in one cycle return undefined data
`timescale 1ns/10ps

module ram_var_width #(
   parameter int log2_width_wr = 5,  // Write width 1 << n, n in 0..5
   parameter int log2_width_rd = 5,  // Read width 1 << n, n in 0..5
   parameter int registers     = 0   // 1 adds an output register on regen_i
) (
   // Write port
   input  logic                                                 wclk,     // Write clock
   input  logic [ram_geom_pkg::bit_addr_bits-log2_width_wr-1:0] waddr_i,  // Write address
   input  logic                                                 we_i,     // Write enable
   input  ram_geom_pkg::byte_en_t                               web_i,    // Byte enables
   input  logic [(1 << log2_width_wr)-1:0]                      data_i,   // Write data
   // Read port
   input  logic                                                 rclk,     // Read clock
   input  logic                                                 reset_i,  // Read side reset
   input  logic [ram_geom_pkg::bit_addr_bits-log2_width_rd-1:0] raddr_i,  // Read address
   input  logic                                                 ren_i,    // Read enable
   input  logic                                                 regen_i,  // Out reg enable
   output logic [(1 << log2_width_rd)-1:0]                      data_o    // Read data
);
   import ram_geom_pkg::*;
   import ram_port_pkg::*;

   wr_req_t   wr_req;   // Decoded write request
   rd_req_t   rd_req;   // Decoded read request
   word_t     rd_word;  // Word held in the read latch
   lane_off_t rd_off;   // Its lane offset

   // Address decode, no clock
   access_decode #(
      .log2_width_wr (log2_width_wr),
      .log2_width_rd (log2_width_rd)
   ) i_decode (
      .waddr_i  (waddr_i),
      .we_i     (we_i),
      .web_i    (web_i),
      .data_i   (data_i),
      .raddr_i  (raddr_i),
      .ren_i    (ren_i),
      .wr_req_o (wr_req),
      .rd_req_o (rd_req)
   );

   // Storage and read latch
   ram_word_array i_array (
      .wclk      (wclk),
      .rclk      (rclk),
      .reset_i   (reset_i),
      .wr_req_i  (wr_req),
      .rd_req_i  (rd_req),
      .rd_word_o (rd_word),
      .rd_off_o  (rd_off)
   );

   // Lane extract and optional output register
   read_lane_select #(
      .log2_width_rd (log2_width_rd),
      .registers     (registers)
   ) i_lane (
      .rclk      (rclk),
      .reset_i   (reset_i),
      .regen_i   (regen_i),
      .rd_word_i (rd_word),
      .rd_off_i  (rd_off),
      .data_o    (data_o)
   );

endmodule

// File: bench/tb_ram_var_width.sv
// Directed testbench for ram_var_width with a 16-bit write port and an 8-bit read port
// wclk and rclk share one clock, output register on (registers 1)
// Only written words are read back since stored data has no reset value
`timescale 1ns/10ps

module tb_ram_var_width;
   import ram_geom_pkg::*;

   localparam int log2_wr      = 4;                         // 16-bit write lane
   localparam int log2_rd      = 3;                         // 8-bit read lane
   localparam int wr_width     = 1 << log2_wr;
   localparam int rd_width     = 1 << log2_rd;
   localparam int waddr_bits   = bit_addr_bits - log2_wr;   // 10
   localparam int raddr_bits   = bit_addr_bits - log2_rd;   // 11
   localparam int mem_bits     = word_bits * word_count;    // 16384 bits
   localparam int drive_dly    = 5;                         // Input skew after rising edge
   localparam int load_timeout = 20;                        // Cycles allowed per wait

   logic                  clk;      // Shared wclk and rclk
   logic                  reset_i;
   logic [waddr_bits-1:0] waddr_i;
   logic                  we_i;
   byte_en_t              web_i;
   logic [wr_width-1:0]   data_i;
   logic [raddr_bits-1:0] raddr_i;
   logic                  ren_i;
   logic                  regen_i;
   logic [rd_width-1:0]   data_o;

   logic                  model_mem [mem_bits];  // Flat bit array mirror of the RAM
   logic [waddr_bits-1:0] wr_addrs [8];          // Addresses written by the lane order test
   integer                seed          = 89865;
   int                    error_count   = 0;
   int                    timeout_count = 0;

   ram_var_width #(
      .log2_width_wr (log2_wr),
      .log2_width_rd (log2_rd),
      .registers     (1)
   ) i_dut (
      .wclk    (clk),
      .waddr_i (waddr_i),
      .we_i    (we_i),
      .web_i   (web_i),
      .data_i  (data_i),
      .rclk    (clk),
      .reset_i (reset_i),
      .raddr_i (raddr_i),
      .ren_i   (ren_i),
      .regen_i (regen_i),
      .data_o  (data_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;  // 100 ns period
   end

   // One rising edge, then the input skew
   task automatic next_cycle();
      @(posedge clk);
      #drive_dly;
   endtask

   // Lane at address a covers bits a*16 up, byte k gated by be[k]
   task automatic model_store(input logic [waddr_bits-1:0] a, input logic [wr_width-1:0] d,
                              input byte_en_t be);
      int base;
      base = int'(a) * wr_width;
      for (int i = 0; i < wr_width; i++) begin
         if (be[i / 8]) begin
            model_mem[base + i] = d[i];
         end
      end
   endtask

   function automatic logic [rd_width-1:0] model_lane(input logic [raddr_bits-1:0] a);
      logic [rd_width-1:0] v;
      int                  base;
      base = int'(a) * rd_width;  // Read lane at bits a*8 up
      for (int i = 0; i < rd_width; i++) begin
         v[i] = model_mem[base + i];
      end
      return v;
   endfunction

   task automatic check_data(input logic [rd_width-1:0] expected);
      assert (data_o === expected) else begin
         error_count++;
         $display("ERR data_o expected %h actual %h at %0t", expected, data_o, $time);
      end
   endtask

   task automatic write_lane(input logic [waddr_bits-1:0] a, input logic [wr_width-1:0] d,
                             input byte_en_t be, input logic we);
      waddr_i = a;
      data_i  = d;
      web_i   = be;
      we_i    = we;
      next_cycle();  // Write lands on this edge
      we_i    = 1'b0;
      if (we) begin
         model_store(a, d, be);
      end
   endtask

   // Counts edges with regen_i high, ren_i dropped after the first edge
   task automatic wait_loads(input int loads);
      int seen;
      int waited;
      seen   = 0;
      waited = 0;
      while (seen < loads && waited < load_timeout) begin
         @(posedge clk);
         if (regen_i) begin
            seen++;
         end
         waited++;
         #drive_dly;
         ren_i = 1'b0;
      end
      if (seen < loads) begin
         timeout_count++;
         error_count++;
         $display("Timeout: output register did not load within %0d cycles", load_timeout);
      end
   endtask

   task automatic read_check(input logic [raddr_bits-1:0] a);
      raddr_i = a;
      ren_i   = 1'b1;
      wait_loads(2);  // Latch edge, then output register edge
      check_data(model_lane(a));
   endtask

   task automatic apply_reset();
      reset_i = 1'b1;
      for (int i = 0; i < 8; i++) begin
         next_cycle();
      end
      reset_i = 1'b0;
   endtask

   task automatic test_reset_zero();
      regen_i = 1'b1;  // Output register keeps loading the cleared latch
      for (int i = 0; i < 4; i++) begin
         next_cycle();
         check_data('0);
      end
   endtask

   task automatic test_lane_order();
      logic [wr_width-1:0] d;
      logic [31:0]         r;
      for (int i = 0; i < 8; i++) begin
         r           = $random(seed);
         wr_addrs[i] = r[waddr_bits-1:0];
         r           = $random(seed);
         d           = r[wr_width-1:0];
         write_lane(wr_addrs[i], d, 4'b0011, 1'b1);
         read_check({wr_addrs[i], 1'b0});  // Low byte sits at bit a*16
         read_check({wr_addrs[i], 1'b1});  // High byte at a*16+8
      end
   endtask

   task automatic test_byte_enables();
      logic [waddr_bits-1:0] a;
      a = waddr_bits'(10'h2a5);
      write_lane(a, 16'hc3a5, 4'b0011, 1'b1);  // Known start value
      write_lane(a, 16'h5a7e, 4'b0001, 1'b1);  // Low byte only
      read_check({a, 1'b0});
      read_check({a, 1'b1});
      write_lane(a, 16'h19e6, 4'b0010, 1'b1);  // High byte only
      read_check({a, 1'b0});
      read_check({a, 1'b1});
   endtask

   task automatic test_regen_hold();
      logic [waddr_bits-1:0] a;
      logic [rd_width-1:0]   held;
      a = waddr_bits'(10'h155);
      write_lane(a, 16'h96e1, 4'b0011, 1'b1);  // Bytes differ
      read_check({a, 1'b0});
      held    = model_lane({a, 1'b0});
      regen_i = 1'b0;
      raddr_i = {a, 1'b1};
      ren_i   = 1'b1;
      next_cycle();  // Latch now holds the high byte
      ren_i   = 1'b0;
      check_data(held);
      for (int i = 0; i < 3; i++) begin
         next_cycle();
         check_data(held);  // Register frozen
      end
      regen_i = 1'b1;
      wait_loads(1);
      check_data(model_lane({a, 1'b1}));
   endtask

   task automatic test_write_disabled();
      logic [waddr_bits-1:0] a;
      a = waddr_bits'(10'h0e3);
      write_lane(a, 16'hbeef, 4'b0011, 1'b1);
      write_lane(a, 16'h4110, 4'b0011, 1'b0);  // we_i low, model untouched
      read_check({a, 1'b0});
      read_check({a, 1'b1});
   endtask

   task automatic test_back_to_back();
      logic [raddr_bits-1:0] rd_list [6];
      for (int i = 0; i < 6; i++) begin
         rd_list[i] = {wr_addrs[i / 2], 1'(i % 2)};  // Both bytes of three words
      end
      regen_i = 1'b1;
      for (int i = 0; i <= 6; i++) begin
         if (i < 6) begin
            raddr_i = rd_list[i];
            ren_i   = 1'b1;
         end else begin
            ren_i = 1'b0;
         end
         next_cycle();
         if (i > 0) begin
            check_data(model_lane(rd_list[i - 1]));  // Two cycles after its ren_i
         end
      end
   endtask

   initial begin
      reset_i = 1'b1;
      waddr_i = '0;
      we_i    = 1'b0;
      web_i   = '0;
      data_i  = '0;
      raddr_i = '0;
      ren_i   = 1'b0;
      regen_i = 1'b1;
      apply_reset();
      test_reset_zero();
      test_lane_order();
      test_byte_enables();
      test_regen_hold();
      test_write_disabled();
      test_back_to_back();
      $display("Run complete: %0d errors, %0d timeouts", error_count, timeout_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: compile.f
design/ram_geom_pkg.sv
design/ram_port_pkg.sv
design/access_decode.sv
design/ram_word_array.sv
design/read_lane_select.sv
design/ram_var_width.sv
bench/tb_ram_var_width.sv

// File: Bender.yml
package:
  name: ram_var_width

sources:
  # Packages first, the modules import them
  - design/ram_geom_pkg.sv
  - design/ram_port_pkg.sv
  # Design, leaves before the top level
  - design/access_decode.sv
  - design/ram_word_array.sv
  - design/read_lane_select.sv
  - design/ram_var_width.sv
  # Testbench
  - target: test
    files:
      - bench/tb_ram_var_width.sv
